// ==== logic/imul_consts.svh ====
/*
 * widths, iteration count and register map for the iterative multiplier
 */

`ifndef IMUL_CONSTS_SVH
`define IMUL_CONSTS_SVH

// --------------------
// widths
// --------------------
// operand and bus data width
`define IMUL_WORD_W 32
// full product width
`define IMUL_PROD_W 64
// one calc cycle per bit of operand b
`define IMUL_ITERS 32
// iteration counter width
`define IMUL_CNT_W 6
// byte address width on the bus
`define IMUL_ADR_W 5

// --------------------
// register byte offsets
// --------------------
`define IMUL_REG_A      5'h00
`define IMUL_REG_B      5'h04
// bit 0 start (write only), bit 1 signed
`define IMUL_REG_CTRL   5'h08
// bit 0 busy, bit 1 done
`define IMUL_REG_STATUS 5'h0C
`define IMUL_REG_RES_LO 5'h10
`define IMUL_REG_RES_HI 5'h14

`endif

// ==== logic/imul_pkg.sv ====
/*
 * shared types for the multiplier and its bus front end
 */

`include "imul_consts.svh"

package imul_pkg;

  // --------------------
  // data vectors
  // --------------------

  // operand a, operand b and every bus data word
  typedef logic [`IMUL_WORD_W-1:0] word_t;

  // full product, accumulator and result register
  typedef logic [`IMUL_PROD_W-1:0] prod_t;

  // byte address seen on the bus
  typedef logic [`IMUL_ADR_W-1:0] wb_adr_t;

  // --------------------
  // control
  // --------------------

  // multiplier sequencing
  // idle waits for a request, calc runs one shift-add per cycle
  // done holds the product until the consumer takes it
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } mul_state_t;

endpackage

// ==== logic/imul_dpath.sv ====
/*
 * multiplier datapath: operand magnitudes, shift registers,
 * accumulator and final sign fix
 */

`include "imul_consts.svh"

module imul_dpath (
  input  logic            clk,
  input  logic            reset,
  input  imul_pkg::word_t req_a,
  input  imul_pkg::word_t req_b,
  input  logic            req_signed,
  input  logic            load,
  input  logic            step,
  output imul_pkg::prod_t resp_result
);

  import imul_pkg::*;

  // sign of each operand, only meaningful in signed mode
  logic  sign_a;
  logic  sign_b;
  // magnitudes presented at load time
  word_t mag_a;
  word_t mag_b;

  // a zero-extended, moves left one bit per step
  prod_t a_sh;
  // b moves right, its low bit picks the add
  word_t b_sh;
  // running partial product
  prod_t acc;
  // product needs negation at the end
  logic  res_neg;

  // --------------------
  // operand prep
  // --------------------
  assign sign_a = req_signed && req_a[`IMUL_WORD_W-1];
  assign sign_b = req_signed && req_b[`IMUL_WORD_W-1];

  // two's complement magnitude, most negative value stays as unsigned 2^31
  assign mag_a = sign_a ? (~req_a + 1'b1) : req_a;
  assign mag_b = sign_b ? (~req_b + 1'b1) : req_b;

  // --------------------
  // shift and add
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      a_sh    <= '0;
      b_sh    <= '0;
      acc     <= '0;
      res_neg <= 1'b0;
    end else if (load) begin
      a_sh    <= {{(`IMUL_PROD_W-`IMUL_WORD_W){1'b0}}, mag_a};
      b_sh    <= mag_b;
      acc     <= '0;
      // negative only when exactly one operand was negative
      res_neg <= sign_a ^ sign_b;
    end else if (step) begin
      // add the current weight of a when this bit of b is set
      if (b_sh[0]) begin
        acc <= acc + a_sh;
      end
      a_sh <= a_sh << 1;
      b_sh <= b_sh >> 1;
    end
  end

  // final sign fix
  assign resp_result = res_neg ? (~acc + 1'b1) : acc;

  // ctrl loads only from idle and steps only in calc
  a_load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(load && step))
    else $error("imul_dpath: load and step high together");

endmodule

// ==== logic/imul_ctrl.sv ====
/*
 * multiplier control: idle, calc and done FSM with iteration counter
 */

`include "imul_consts.svh"

module imul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step
);

  import imul_pkg::*;

  // count value of the final calc cycle
  localparam logic [`IMUL_CNT_W-1:0] LAST_CNT = `IMUL_ITERS - 1;

  mul_state_t             state;
  mul_state_t             state_next;
  // calc cycles already spent
  logic [`IMUL_CNT_W-1:0] count;
  logic                   last_iter;

  assign last_iter = (count == LAST_CNT);

  // --------------------
  // next state
  // --------------------
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // request taken here, rdy is high throughout idle
        if (req_val) begin
          state_next = CALC;
        end
      end
      CALC: begin
        if (last_iter) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // back-pressure holds us here
        if (resp_rdy) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      // counter only runs in calc and is parked at zero elsewhere
      if (state == CALC && !last_iter) begin
        count <= count + 1'b1;
      end else begin
        count <= '0;
      end
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign req_rdy  = (state == IDLE);
  // load on the request transfer edge
  assign load     = req_rdy && req_val;
  // one shift-add per calc cycle
  assign step     = (state == CALC);
  assign resp_val = (state == DONE);

  // a valid response is never withdrawn before it is taken
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else $error("imul_ctrl: resp_val dropped before resp_rdy");

  a_cnt_range: assert property (@(posedge clk) disable iff (reset)
    count <= LAST_CNT)
    else $error("imul_ctrl: iteration count out of range");

endmodule

// ==== logic/imul_iterative.sv ====
/*
 * iterative multiplier unit, control and datapath behind val/rdy
 */

module imul_iterative (
  input  logic            clk,
  input  logic            reset,
  input  logic            req_val,
  output logic            req_rdy,
  input  imul_pkg::word_t req_a,
  input  imul_pkg::word_t req_b,
  input  logic            req_signed,
  output logic            resp_val,
  input  logic            resp_rdy,
  output imul_pkg::prod_t resp_result
);

  // capture operands on the request transfer
  logic load;
  // one shift-add per calc cycle
  logic step;

  // sequencing and handshakes
  imul_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step)
  );

  // operand regs, accumulator and sign fix
  imul_dpath dpath (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (req_signed),
    .load        (load),
    .step        (step),
    .resp_result (resp_result)
  );

endmodule

// ==== logic/imul_wb_regs.sv ====
/*
 * wishbone classic slave register block: operands, control, status
 * and result registers steering the multiplier over val/rdy
 */

`include "imul_consts.svh"

module imul_wb_regs (
  input  logic              clk,
  input  logic              reset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  imul_pkg::wb_adr_t wb_adr,
  input  imul_pkg::word_t   wb_dat_w,
  output imul_pkg::word_t   wb_dat_r,
  output logic              wb_ack,
  output logic              req_val,
  output imul_pkg::word_t   req_a,
  output imul_pkg::word_t   req_b,
  output logic              req_signed,
  input  logic              req_rdy,
  input  logic              resp_val,
  input  imul_pkg::prod_t   resp_result,
  output logic              resp_rdy
);

  import imul_pkg::*;

  // new bus access, ack low so a held stb is not seen twice
  logic  bus_go;
  logic  wr_go;
  logic  rd_go;
  // accepted start write
  logic  start_go;
  // read of RES_HI releases the product
  logic  done_clr;
  logic  req_go;
  logic  resp_go;
  // multiply in progress, from start until the product is stored
  logic  busy;
  // product stored and not yet released
  logic  done;
  prod_t res_reg;
  word_t rd_word;

  // --------------------
  // bus decode
  // --------------------
  assign bus_go   = wb_cyc && wb_stb && !wb_ack;
  assign wr_go    = bus_go && wb_we;
  assign rd_go    = bus_go && !wb_we;
  // start ignored while busy
  assign start_go = wr_go && (wb_adr == `IMUL_REG_CTRL) && wb_dat_w[0] && !busy;
  assign done_clr = rd_go && (wb_adr == `IMUL_REG_RES_HI);

  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;
  // back-pressure, no new product while the last one is unread
  assign resp_rdy = !done;

  // read mux, unmapped offsets return zero
  always_comb begin
    case (wb_adr)
      `IMUL_REG_A:      rd_word = req_a;
      `IMUL_REG_B:      rd_word = req_b;
      // start bit always reads zero
      `IMUL_REG_CTRL:   rd_word = {{(`IMUL_WORD_W-2){1'b0}}, req_signed, 1'b0};
      `IMUL_REG_STATUS: rd_word = {{(`IMUL_WORD_W-2){1'b0}}, done, busy};
      `IMUL_REG_RES_LO: rd_word = res_reg[`IMUL_WORD_W-1:0];
      `IMUL_REG_RES_HI: rd_word = res_reg[`IMUL_PROD_W-1:`IMUL_WORD_W];
      default:          rd_word = '0;
    endcase
  end

  // single-cycle ack, data registered alongside it
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
    end else begin
      wb_ack   <= bus_go;
      wb_dat_r <= rd_go ? rd_word : '0;
    end
  end

  // --------------------
  // operand and mode regs
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      req_a      <= '0;
      req_b      <= '0;
      req_signed <= 1'b0;
    end else if (wr_go) begin
      // operands are sampled by the multiplier at load only
      if (wb_adr == `IMUL_REG_A) begin
        req_a <= wb_dat_w;
      end
      if (wb_adr == `IMUL_REG_B) begin
        req_b <= wb_dat_w;
      end
      if (wb_adr == `IMUL_REG_CTRL) begin
        req_signed <= wb_dat_w[1];
      end
    end
  end

  // --------------------
  // handshake and status
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      req_val <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
      res_reg <= '0;
    end else begin
      // request held until the multiplier takes it
      if (start_go) begin
        req_val <= 1'b1;
        busy    <= 1'b1;
      end else if (req_go) begin
        req_val <= 1'b0;
      end
      if (done_clr) begin
        done <= 1'b0;
      end
      // resp_rdy keeps this apart from done_clr
      if (resp_go) begin
        res_reg <= resp_result;
        done    <= 1'b1;
        busy    <= 1'b0;
      end
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("imul_wb_regs: wb_ack high for two cycles");

  // a pending request always belongs to a running multiply
  a_req_busy: assert property (@(posedge clk) disable iff (reset)
    !busy |-> !req_val)
    else $error("imul_wb_regs: req_val high while not busy");

endmodule

// ==== logic/imul_wb_top.sv ====
/*
 * top level: wishbone register block driving the iterative multiplier
 */

module imul_wb_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  imul_pkg::wb_adr_t wb_adr,
  input  imul_pkg::word_t   wb_dat_w,
  output imul_pkg::word_t   wb_dat_r,
  output logic              wb_ack
);

  import imul_pkg::*;

  // request side
  logic  req_val;
  logic  req_rdy;
  word_t req_a;
  word_t req_b;
  logic  req_signed;
  // response side
  logic  resp_val;
  logic  resp_rdy;
  prod_t resp_result;

  imul_wb_regs regs (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .req_val     (req_val),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (req_signed),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .resp_rdy    (resp_rdy)
  );

  imul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (req_signed),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

// ==== tests/imul_wb_tb.sv ====
/*
 * testbench for the wishbone multiplier: clock, reset, bus tasks,
 * directed and random multiplies, back-pressure, watchdog and checks
 */

`include "imul_consts.svh"

module imul_wb_tb;

  import imul_pkg::*;

  localparam int PERIOD       = 20;
  localparam int RESET_CYCLES = 16;
  localparam int N_UNS_RAND   = 40;
  localparam int N_SGN_RAND   = 24;
  // corners, random pairs, busy test and the two back-pressure products
  localparam int N_MULS = 3 + N_UNS_RAND + 3 + N_SGN_RAND + 1 + 2;
  // extra slots for reset and readback checks and the long idle waits
  localparam int N_OPS  = N_MULS + 6;
  localparam int TIMEOUT = (N_OPS * 80 + RESET_CYCLES) * PERIOD;
  // unmapped offsets
  localparam wb_adr_t ADR_HOLE_0 = 5'h18;
  localparam wb_adr_t ADR_HOLE_1 = 5'h1C;

  logic    clk;
  logic    reset;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  wb_adr_t wb_adr;
  word_t   wb_dat_w;
  word_t   wb_dat_r;
  logic    wb_ack;

  imul_wb_top dut (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  // --------------------
  // clock and watchdog
  // --------------------
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    fail_run("watchdog expired before all tests finished");
  end

  // --------------------
  // failure and checks
  // --------------------
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got == exp)
      else fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
  endtask

  // ack only ever answers a request seen on the previous edge
  a_ack_follows_req: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else fail_run("wb_ack raised without a bus request");

  // one-cycle ack pulse
  a_ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else fail_run("wb_ack held high for more than one cycle");

  // reference product from wide arithmetic
  function automatic prod_t expected_product(input word_t a, input word_t b, input logic sgn);
    logic signed [`IMUL_PROD_W-1:0] sa;
    logic signed [`IMUL_PROD_W-1:0] sb;
    prod_t ua;
    prod_t ub;
    prod_t res;
    sa = {{`IMUL_WORD_W{a[`IMUL_WORD_W-1]}}, a};
    sb = {{`IMUL_WORD_W{b[`IMUL_WORD_W-1]}}, b};
    ua = {{`IMUL_WORD_W{1'b0}}, a};
    ub = {{`IMUL_WORD_W{1'b0}}, b};
    if (sgn) begin
      res = sa * sb;
    end else begin
      res = ua * ub;
    end
    return res;
  endfunction

  // --------------------
  // bus tasks
  // --------------------
  // classic cycle, request held until ack, data sampled with ack
  task automatic wb_access(input logic we, input wb_adr_t adr, input word_t wdata,
                           output word_t rdata);
    int waited;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    @(negedge clk);
    while (!wb_ack) begin
      waited++;
      if (waited >= 8) begin
        fail_run("bus access got no wb_ack within 8 cycles");
      end
      @(negedge clk);
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input word_t data);
    word_t unused_rd;
    wb_access(1'b1, adr, data, unused_rd);
  endtask

  task automatic wb_read(input wb_adr_t adr, output word_t data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic read_expect(input string name, input wb_adr_t adr, input word_t exp);
    word_t rd;
    wb_read(adr, rd);
    check_word(name, rd, exp);
  endtask

  // --------------------
  // multiply helpers
  // --------------------
  task automatic start_mul(input word_t a, input word_t b, input logic sgn);
    wb_write(`IMUL_REG_A, a);
    wb_write(`IMUL_REG_B, b);
    wb_write(`IMUL_REG_CTRL, sgn ? 32'h3 : 32'h1);
  endtask

  // poll until busy drops, then done must be the only bit set
  task automatic wait_ready();
    word_t st;
    int    polls;
    polls = 0;
    wb_read(`IMUL_REG_STATUS, st);
    while (st[0]) begin
      check_word("STATUS", st, 32'h1);
      polls++;
      if (polls > 40) begin
        fail_run("multiply never finished, busy stuck high");
      end
      wb_read(`IMUL_REG_STATUS, st);
    end
    check_word("STATUS", st, 32'h2);
  endtask

  // RES_LO first, RES_HI last since it releases the product
  task automatic check_product(input word_t a, input word_t b, input logic sgn);
    prod_t exp;
    exp = expected_product(a, b, sgn);
    read_expect("RES_LO", `IMUL_REG_RES_LO, exp[`IMUL_WORD_W-1:0]);
    read_expect("RES_HI", `IMUL_REG_RES_HI, exp[`IMUL_PROD_W-1:`IMUL_WORD_W]);
  endtask

  task automatic run_mul(input word_t a, input word_t b, input logic sgn);
    start_mul(a, b, sgn);
    read_expect("STATUS after start", `IMUL_REG_STATUS, 32'h1);
    wait_ready();
    check_product(a, b, sgn);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    word_t       a;
    word_t       b;
    word_t       a2;
    word_t       b2;
    prod_t       first;
    int          i;
    void'($urandom(32'h1c45));
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    reset    = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // everything reads zero after reset
    read_expect("STATUS", `IMUL_REG_STATUS, 32'h0);
    read_expect("RES_LO", `IMUL_REG_RES_LO, 32'h0);
    read_expect("RES_HI", `IMUL_REG_RES_HI, 32'h0);
    read_expect("A", `IMUL_REG_A, 32'h0);
    read_expect("B", `IMUL_REG_B, 32'h0);
    read_expect("CTRL", `IMUL_REG_CTRL, 32'h0);

    // readback, start bit reads zero, holes read zero
    a = $urandom();
    b = $urandom();
    wb_write(`IMUL_REG_A, a);
    read_expect("A", `IMUL_REG_A, a);
    wb_write(`IMUL_REG_B, b);
    read_expect("B", `IMUL_REG_B, b);
    wb_write(`IMUL_REG_CTRL, 32'hFFFF_FFFE);
    read_expect("CTRL", `IMUL_REG_CTRL, 32'h2);
    wb_write(`IMUL_REG_CTRL, 32'h0);
    read_expect("CTRL", `IMUL_REG_CTRL, 32'h0);
    read_expect("unmapped", ADR_HOLE_0, 32'h0);
    wb_write(ADR_HOLE_1, 32'hFFFF_FFFF);
    read_expect("unmapped", ADR_HOLE_1, 32'h0);

    // unsigned corners then random pairs
    run_mul(32'h0, 32'h1234_5678, 1'b0);
    run_mul(32'h1, 32'hDEAD_BEEF, 1'b0);
    run_mul(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
    for (i = 0; i < N_UNS_RAND; i++) begin
      run_mul($urandom(), $urandom(), 1'b0);
    end

    // signed corners then random pairs
    run_mul(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
    run_mul(32'hFFFF_FFF9, 32'h0000_0007, 1'b1);
    run_mul(32'h8000_0000, 32'h8000_0000, 1'b1);
    for (i = 0; i < N_SGN_RAND; i++) begin
      run_mul($urandom(), $urandom(), 1'b1);
    end

    // second start while busy is dropped, result keeps first operands
    a = $urandom();
    b = $urandom();
    start_mul(a, b, 1'b0);
    read_expect("STATUS after start", `IMUL_REG_STATUS, 32'h1);
    // start bit is write only
    read_expect("CTRL", `IMUL_REG_CTRL, 32'h0);
    wb_write(`IMUL_REG_A, ~a);
    wb_write(`IMUL_REG_CTRL, 32'h3);
    read_expect("CTRL", `IMUL_REG_CTRL, 32'h2);
    wait_ready();
    check_product(a, b, 1'b0);
    // a dropped start leaves no multiply queued behind the first
    repeat (`IMUL_ITERS + 8) @(negedge clk);
    read_expect("STATUS", `IMUL_REG_STATUS, 32'h0);

    // back-pressure, product left unread
    a     = $urandom();
    b     = $urandom();
    a2    = $urandom();
    b2    = $urandom();
    first = expected_product(a, b, 1'b0);
    start_mul(a, b, 1'b0);
    wait_ready();
    repeat (100) @(negedge clk);
    read_expect("STATUS", `IMUL_REG_STATUS, 32'h2);
    read_expect("RES_LO", `IMUL_REG_RES_LO, first[`IMUL_WORD_W-1:0]);
    // second multiply finishes but cannot be stored yet
    start_mul(a2, b2, 1'b1);
    read_expect("STATUS", `IMUL_REG_STATUS, 32'h3);
    repeat (60) @(negedge clk);
    read_expect("STATUS", `IMUL_REG_STATUS, 32'h3);
    read_expect("RES_LO", `IMUL_REG_RES_LO, first[`IMUL_WORD_W-1:0]);
    read_expect("RES_HI", `IMUL_REG_RES_HI, first[`IMUL_PROD_W-1:`IMUL_WORD_W]);
    // releasing the first product lets the second one in
    wait_ready();
    check_product(a2, b2, 1'b1);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+logic
logic/imul_pkg.sv
logic/imul_dpath.sv
logic/imul_ctrl.sv
logic/imul_iterative.sv
logic/imul_wb_regs.sv
logic/imul_wb_top.sv
tests/imul_wb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the multiplier testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module imul_wb_tb \
  -f sim.f \
  --Mdir obj_dir -o imul_wb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/imul_wb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
